// ==== clic.f ====
+incdir+rtl
rtl/clic_pkg.sv
rtl/clic_csr_if.sv
rtl/clic_update_if.sv
rtl/clic_csr_bank.sv
rtl/clic_timer.sv
rtl/clic_arbiter.sv
rtl/clic_epc_stack.sv
rtl/clic_top.sv
tests/clic_asserts.sv
tests/clic_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the clic testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module clic_tb -f clic.f -o clic_sim > build.log 2>&1 &&
  ./obj_dir/clic_sim > sim.log 2>&1

cat sim.log 2>/dev/null
grep -q "^Testbench passed$" sim.log 2>/dev/null && echo "simulation PASS" ||
  { echo "simulation FAIL, see build.log and sim.log"; exit 1; }

// ==== tests/clic_tb.sv ====
// clic testbench
`timescale 1ns/1ps
`include "clic_cfg.svh"

module clic_tb
  import clic_pkg::*;
();

  localparam pc_t NORMAL_PC = 16'h0100;
  localparam int LEN_CSR = 80, LEN_TAKE = 60, LEN_RAND = 600, LEN_TIMER = 60;
  localparam int CYCLE_LIMIT = 2 * (LEN_CSR + LEN_TAKE + LEN_RAND + LEN_TIMER);

  typedef struct {
    logic    intr;
    pc_sel_e sel;
    pc_t     addr;
    logic    push;
    logic    pop;
    logic    thr_we;
    prio_t   thr;
    int      clr;
  } decide_t;

  logic clk = 1'b0;
  logic reset_i, csr_enable_i;
  csr_addr_t csr_addr_i;
  csr_op_e csr_op_i;
  logic [4:0] rs1_zimm_i;
  word_t rs1_data_i, csr_data_o;
  pc_t pc_i, int_addr_o;
  pc_sel_e pc_sel_o;
  depth_t level_o;
  logic interrupt_o;

  // register mirror
  entry_t m_ent [`CLIC_VEC_SIZE];
  vec_addr_t m_vec [`CLIC_VEC_SIZE];
  prio_t m_thresh;
  word_t m_timer;
  int m_depth;
  pc_t m_stk_pc [`CLIC_STACK_DEPTH];
  prio_t m_stk_th [`CLIC_STACK_DEPTH];

  word_t lfsr = 32'hd7a68605;
  int word_errs = 0, pc_errs = 0, sel_errs = 0, bit_errs = 0, other_errs = 0;
  int cycles = 0;

  clic_top clic_top_inst (.*);

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("run stopped, cycle limit of %0d reached", CYCLE_LIMIT);
      $display("Testbench failed");
      $finish;
    end
  end

  function automatic word_t rand_bits(int n);
    word_t v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};  // taps 32 22 2 1
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic word_t csr_rule(csr_op_e op, word_t old, word_t rs1, logic [4:0] zimm);
    word_t src = op[2] ? {27'b0, zimm} : rs1;  // bit 2 marks immediate forms
    case (op[1:0])
      2'b01: return src;
      2'b10: return old | src;
      2'b11: return old & ~src;
      default: return old;
    endcase
  endfunction

  function automatic word_t read_model(csr_addr_t a);
    if (a == `CLIC_CSR_TIMER) return m_timer;
    if (a == `CLIC_CSR_THRESH) return {29'b0, m_thresh};
    if (a == `CLIC_CSR_DEPTH) return word_t'(m_depth);
    for (int k = 0; k < `CLIC_VEC_SIZE; k++) begin
      if (a == `CLIC_CSR_VEC_BASE + csr_addr_t'(k)) return {18'b0, m_vec[k]};
      if (a == `CLIC_CSR_ENTRY_BASE + csr_addr_t'(k)) return {27'b0, m_ent[k]};
    end
    return '0;
  endfunction

  // expected decision from the mirror
  function automatic decide_t ref_decide(pc_t pc);
    decide_t d = '{1'b0, PC_NORMAL, pc, 0, 0, 0, 0, -1};
    int best = -1;
    prio_t bp = '0;
    for (int k = 0; k < `CLIC_VEC_SIZE; k++) begin
      if (m_ent[k].enabled && m_ent[k].pended && m_ent[k].prio >= m_thresh &&
          (best < 0 || m_ent[k].prio >= bp)) begin
        best = k;
        bp = m_ent[k].prio;
      end
    end
    if (best >= 0 && (bp > m_thresh || pc == `CLIC_RET_MARKER)) begin
      d.intr = 1'b1;
      d.sel = PC_INTERRUPT;
      d.addr = {m_vec[best], 2'b00};
      d.clr = best;
      if (bp > m_thresh) begin  // take, otherwise tail-chain
        d.push = 1'b1;
        d.thr_we = 1'b1;
        d.thr = bp;
      end
    end else if (pc == `CLIC_RET_MARKER) begin
      d.sel = PC_INTERRUPT;
      d.pop = 1'b1;
      d.thr_we = 1'b1;
      d.addr = (m_depth == 0) ? '0 : m_stk_pc[m_depth-1];
      d.thr = (m_depth == 0) ? '0 : m_stk_th[m_depth-1];
    end
    return d;
  endfunction

  task automatic check_word(string name, word_t exp, word_t got);
    if (exp !== got) begin
      word_errs++;
      $display("Error at %0t: %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  task automatic check_pc(string name, pc_t exp, pc_t got);
    if (exp !== got) begin
      pc_errs++;
      $display("Error at %0t: %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  task automatic check_sel(string name, pc_sel_e exp, pc_sel_e got);
    if (exp !== got) begin
      sel_errs++;
      $display("Error at %0t: %s expected %s got %s", $time, name, exp.name(), got.name());
    end
  endtask

  task automatic check_bit(string name, logic exp, logic got);
    if (exp !== got) begin
      bit_errs++;
      $display("Error at %0t: %s expected %b got %b", $time, name, exp, got);
    end
  endtask

  task automatic model_step();
    decide_t r = ref_decide(pc_i);
    logic we = csr_enable_i;
    word_t w = csr_rule(csr_op_i, read_model(csr_addr_i), rs1_data_i, rs1_zimm_i);
    logic tpend = (m_timer == 1) && !(we && csr_addr_i == `CLIC_CSR_TIMER);
    for (int k = 0; k < `CLIC_VEC_SIZE; k++) begin
      if (we && csr_addr_i == `CLIC_CSR_ENTRY_BASE + csr_addr_t'(k)) m_ent[k] = entry_t'(w[4:0]);
      if (r.clr == k) m_ent[k].pended = 1'b0;
      if (we && csr_addr_i == `CLIC_CSR_VEC_BASE + csr_addr_t'(k)) m_vec[k] = w[13:0];
    end
    if (tpend) m_ent[0].pended = 1'b1;
    if (r.push && m_depth < `CLIC_STACK_DEPTH) begin
      m_stk_pc[m_depth] = pc_i;
      m_stk_th[m_depth] = m_thresh;  // threshold before the take
      m_depth++;
    end else if (r.pop && m_depth > 0) begin
      m_depth--;
    end
    if (r.thr_we) m_thresh = r.thr;
    else if (we && csr_addr_i == `CLIC_CSR_THRESH) m_thresh = w[2:0];
    if (we && csr_addr_i == `CLIC_CSR_TIMER) m_timer = w;
    else if (m_timer != 0) m_timer = m_timer - 1;
  endtask

  // compare process, outputs settle by the falling edge
  always @(negedge clk) begin
    decide_t r;
    if (reset_i) begin
      for (int k = 0; k < `CLIC_VEC_SIZE; k++) begin
        m_ent[k] = '0;
        m_vec[k] = '0;
      end
      m_thresh = '0;
      m_timer = '0;
      m_depth = 0;
    end else begin
      r = ref_decide(pc_i);
      check_bit("interrupt_o", r.intr, interrupt_o);
      check_sel("pc_sel_o", r.sel, pc_sel_o);
      check_pc("int_addr_o", r.addr, int_addr_o);
      check_word("level_o", word_t'(m_depth), word_t'(level_o));
      check_word("csr_data_o", read_model(csr_addr_i), csr_data_o);
      model_step();
    end
  end

  task automatic csr_access(csr_op_e op, csr_addr_t addr, word_t data, logic [4:0] zimm);
    @(posedge clk);
    csr_enable_i <= 1'b1;
    csr_op_i <= op;
    csr_addr_i <= addr;
    rs1_data_i <= data;
    rs1_zimm_i <= zimm;
    @(posedge clk);
    csr_enable_i <= 1'b0;
  endtask

  task automatic write_csr(csr_addr_t addr, word_t data);
    csr_access(CSR_RW, addr, data, 5'd0);
  endtask

  task automatic marker_pulse();
    @(posedge clk) pc_i <= `CLIC_RET_MARKER;
    @(posedge clk) pc_i <= NORMAL_PC;
  endtask

  task automatic clear_entries();
    for (int k = 0; k < `CLIC_VEC_SIZE; k++) write_csr(`CLIC_CSR_ENTRY_BASE + csr_addr_t'(k), 0);
    write_csr(`CLIC_CSR_THRESH, 0);
  endtask

  // return until the stack is empty, marker only while depth is nonzero
  task automatic drain();
    int guard = 0;
    @(negedge clk);
    while (level_o != '0 && guard < 40) begin
      marker_pulse();
      @(negedge clk);
      guard++;
    end
    if (level_o != '0) begin
      other_errs++;
      $display("stack did not drain back to empty");
    end
  endtask

  initial begin
    csr_op_e ops [6];
    int wait_n;
    ops = '{CSR_RW, CSR_RS, CSR_RC, CSR_RWI, CSR_RSI, CSR_RCI};
    reset_i = 1'b1;
    csr_enable_i = 1'b0;
    csr_addr_i = '0;
    csr_op_i = CSR_RW;
    rs1_zimm_i = '0;
    rs1_data_i = '0;
    pc_i = NORMAL_PC;
    repeat (2) @(posedge clk);
    reset_i <= 1'b0;

    // csr ops with threshold at the top so nothing is taken
    write_csr(`CLIC_CSR_THRESH, 7);
    foreach (ops[i]) begin
      csr_access(ops[i], `CLIC_CSR_VEC_BASE + 12'd3, rand_bits(32), rand_bits(5));
      csr_access(ops[i], `CLIC_CSR_ENTRY_BASE + 12'd5, rand_bits(32), rand_bits(5));
    end
    foreach (ops[i]) csr_access(ops[i], `CLIC_CSR_THRESH, rand_bits(32), rand_bits(5));
    drain();

    // take then return
    clear_entries();
    write_csr(`CLIC_CSR_VEC_BASE + 12'd2, 32'h0123);
    write_csr(`CLIC_CSR_ENTRY_BASE + 12'd2, {27'b0, 3'd5, 1'b1, 1'b1});
    repeat (2) @(posedge clk);
    marker_pulse();

    // tail-chain at an equal priority
    write_csr(`CLIC_CSR_VEC_BASE + 12'd1, 32'h0200);
    write_csr(`CLIC_CSR_VEC_BASE + 12'd4, 32'h0300);
    write_csr(`CLIC_CSR_ENTRY_BASE + 12'd1, {27'b0, 3'd5, 1'b1, 1'b1});
    write_csr(`CLIC_CSR_ENTRY_BASE + 12'd4, {27'b0, 3'd5, 1'b1, 1'b1});
    marker_pulse();
    marker_pulse();
    drain();

    // random arbitration rounds, everything competes once the threshold drops
    for (int round = 0; round < 6; round++) begin
      clear_entries();
      write_csr(`CLIC_CSR_THRESH, 7);
      for (int k = 0; k < `CLIC_VEC_SIZE; k++) begin
        write_csr(`CLIC_CSR_VEC_BASE + csr_addr_t'(k), rand_bits(14));
        write_csr(`CLIC_CSR_ENTRY_BASE + csr_addr_t'(k), rand_bits(5));
      end
      write_csr(`CLIC_CSR_THRESH, 0);
      repeat (3) @(posedge clk);
      drain();
    end

    // timer pends vector 0
    clear_entries();
    write_csr(`CLIC_CSR_VEC_BASE, 32'h0040);
    write_csr(`CLIC_CSR_ENTRY_BASE, {27'b0, 3'd6, 1'b1, 1'b0});
    write_csr(`CLIC_CSR_TIMER, 12);
    wait_n = 0;
    @(negedge clk);
    while (!interrupt_o && wait_n < 30) begin
      @(negedge clk);
      wait_n++;
    end
    if (!interrupt_o) begin
      other_errs++;
      $display("timer interrupt never arrived");
    end
    drain();

    repeat (2) @(posedge clk);
    $display("errors: word %0d pc %0d sel %0d bit %0d other %0d",
             word_errs, pc_errs, sel_errs, bit_errs, other_errs);
    if (word_errs + pc_errs + sel_errs + bit_errs + other_errs == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== tests/clic_asserts.sv ====
// clic protocol assertions
`timescale 1ns/1ps
`include "clic_cfg.svh"

module clic_asserts
  import clic_pkg::*;
(
  input logic    clk,
  input logic    reset_i,
  input logic    push_i,
  input logic    pop_i,
  input depth_t  depth_i,
  input logic    interrupt_i,
  input pc_sel_e pc_sel_i
);

  assert property (@(posedge clk) disable iff (reset_i)
    push_i |-> depth_i != depth_t'(`CLIC_STACK_DEPTH))
    else $error("push on a full stack");

  assert property (@(posedge clk) disable iff (reset_i) pop_i |-> depth_i != '0)
    else $error("pop on an empty stack");

  assert property (@(posedge clk) disable iff (reset_i) !(push_i && pop_i))
    else $error("push and pop in the same cycle");

  assert property (@(posedge clk) disable iff (reset_i) interrupt_i |-> pc_sel_i == PC_INTERRUPT)
    else $error("interrupt without interrupt pc select");

endmodule

bind clic_top clic_asserts clic_asserts_inst (
  .clk(clk), .reset_i(reset_i), .push_i(upd_if.push), .pop_i(upd_if.pop),
  .depth_i(level_o), .interrupt_i(interrupt_o), .pc_sel_i(pc_sel_o)
);

// ==== rtl/clic_top.sv ====
// core local interrupt controller
`timescale 1ns/1ps
`include "clic_cfg.svh"

module clic_top
  import clic_pkg::*;
(
  input  logic                        clk,
  input  logic                        reset_i,
  input  logic                        csr_enable_i,
  input  csr_addr_t                   csr_addr_i,
  input  csr_op_e                     csr_op_i,
  input  logic [`CLIC_ZIMM_WIDTH-1:0] rs1_zimm_i,
  input  word_t                       rs1_data_i,
  input  pc_t                         pc_i,
  output word_t                       csr_data_o,
  output pc_t                         int_addr_o,
  output pc_sel_e                     pc_sel_o,
  output depth_t                      level_o,     // stack depth
  output logic                        interrupt_o
);

  clic_csr_if    csr_if ();
  clic_update_if upd_if ();

  entry_t    [`CLIC_VEC_SIZE-1:0] entries;
  vec_addr_t [`CLIC_VEC_SIZE-1:0] vectors;
  prio_t                          thresh;
  word_t                          timer_count;
  logic                           timer_pend;
  stack_entry_t                   stack_top;

  assign csr_if.csr_enable = csr_enable_i;
  assign csr_if.csr_addr   = csr_addr_i;
  assign csr_if.csr_op     = csr_op_i;
  assign csr_if.rs1_zimm   = rs1_zimm_i;
  assign csr_if.rs1_data   = rs1_data_i;

  // input side
  clic_csr_bank csr_bank_inst (
    .clk, .reset_i, .csr(csr_if.bank), .upd(upd_if.bank),
    .timer_data_i(timer_count), .timer_pend_i(timer_pend), .depth_i(level_o),
    .entries_o(entries), .vectors_o(vectors), .thresh_o(thresh), .csr_data_o
  );

  clic_timer timer_inst (
    .clk, .reset_i, .csr(csr_if.timer), .count_o(timer_count), .pend_req_o(timer_pend)
  );

  // processing
  clic_arbiter arbiter_inst (
    .entries_i(entries), .vectors_i(vectors), .thresh_i(thresh), .pc_i,
    .top_i(stack_top), .upd(upd_if.arbiter), .int_addr_o, .pc_sel_o, .interrupt_o
  );

  // output side
  clic_epc_stack epc_stack_inst (
    .clk, .reset_i, .upd(upd_if.stack), .pc_i, .thresh_i(thresh),
    .top_o(stack_top), .depth_o(level_o)
  );

endmodule

// ==== rtl/clic_epc_stack.sv ====
// return pc and threshold stack
`timescale 1ns/1ps
`include "clic_cfg.svh"

module clic_epc_stack
  import clic_pkg::*;
(
  input  logic            clk,
  input  logic            reset_i,
  clic_update_if.stack    upd,
  input  pc_t             pc_i,
  input  prio_t           thresh_i,
  output stack_entry_t    top_o,
  output depth_t          depth_o
);

  stack_entry_t               mem [`CLIC_STACK_DEPTH];
  depth_t                     depth_q;
  logic [`CLIC_PRIO_WIDTH-1:0] wr_ptr;
  logic [`CLIC_PRIO_WIDTH-1:0] top_ptr;
  logic                       do_push;
  logic                       do_pop;

  // overflow and underflow are dropped here
  assign do_push = upd.push && (depth_q != depth_t'(`CLIC_STACK_DEPTH));
  assign do_pop  = upd.pop && (depth_q != '0);

  assign wr_ptr  = depth_q[`CLIC_PRIO_WIDTH-1:0];
  assign top_ptr = wr_ptr - 1'b1;  // wraps to the last slot when full

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= '{pc: pc_i, thresh: thresh_i};
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      depth_q <= '0;
    end else if (do_push) begin
      depth_q <= depth_q + 1'b1;
    end else if (do_pop) begin
      depth_q <= depth_q - 1'b1;
    end
  end

  // empty stack shows zeros instead of stale slots
  assign top_o   = (depth_q == '0) ? '0 : mem[top_ptr];
  assign depth_o = depth_q;

endmodule

// ==== rtl/clic_arbiter.sv ====
// priority search and interrupt decision
`timescale 1ns/1ps
`include "clic_cfg.svh"

module clic_arbiter
  import clic_pkg::*;
(
  input  entry_t    [`CLIC_VEC_SIZE-1:0] entries_i,
  input  vec_addr_t [`CLIC_VEC_SIZE-1:0] vectors_i,
  input  prio_t                          thresh_i,
  input  pc_t                            pc_i,
  input  stack_entry_t                   top_i,
  clic_update_if.arbiter                 upd,
  output pc_t                            int_addr_o,
  output pc_sel_e                        pc_sel_o,
  output logic                           interrupt_o
);

  typedef logic [$clog2(`CLIC_VEC_SIZE)-1:0] idx_t;

  prio_t     win_prio;
  vec_addr_t win_vec;
  idx_t      win_idx;
  logic      win_valid;
  logic      at_marker;

  assign at_marker = pc_i == `CLIC_RET_MARKER;

  // linear scan, seeded with the threshold so only prio >= thresh can win
  always_comb begin
    win_prio  = thresh_i;
    win_vec   = '0;
    win_idx   = '0;
    win_valid = 1'b0;
    for (int k = 0; k < `CLIC_VEC_SIZE; k++) begin
      // >= lets the later index win a tie
      if (entries_i[k].enabled && entries_i[k].pended &&
          (entries_i[k].prio >= win_prio)) begin
        win_prio  = entries_i[k].prio;
        win_vec   = vectors_i[k];
        win_idx   = idx_t'(k);
        win_valid = 1'b1;
      end
    end
  end

  // take, tail-chain, return or none
  always_comb begin
    upd.pend_clr    = '0;
    upd.thresh_we   = 1'b0;
    upd.thresh_data = '0;
    upd.push        = 1'b0;
    upd.pop         = 1'b0;
    int_addr_o      = pc_i;
    pc_sel_o        = PC_NORMAL;
    interrupt_o     = 1'b0;

    if (win_valid && (win_prio > thresh_i)) begin
      // take: save pc and raise the threshold
      upd.push              = 1'b1;
      upd.thresh_we         = 1'b1;
      upd.thresh_data       = win_prio;
      upd.pend_clr[win_idx] = 1'b1;
      int_addr_o            = {win_vec, 2'b00};  // word to byte address
      pc_sel_o              = PC_INTERRUPT;
      interrupt_o           = 1'b1;
    end else if (at_marker && win_valid) begin
      // tail-chain, stack and threshold stay as they are
      upd.pend_clr[win_idx] = 1'b1;
      int_addr_o            = {win_vec, 2'b00};
      pc_sel_o              = PC_INTERRUPT;
      interrupt_o           = 1'b1;
    end else if (at_marker) begin
      // return to the saved pc
      upd.pop         = 1'b1;
      upd.thresh_we   = 1'b1;
      upd.thresh_data = top_i.thresh;
      int_addr_o      = top_i.pc;
      pc_sel_o        = PC_INTERRUPT;
    end
  end

endmodule

// ==== rtl/clic_timer.sv ====
// down counting timer csr
`timescale 1ns/1ps
`include "clic_cfg.svh"

module clic_timer
  import clic_pkg::*;
(
  input  logic     clk,
  input  logic     reset_i,
  clic_csr_if.timer csr,
  output word_t    count_o,
  output logic     pend_req_o
);

  word_t count_q;
  logic  timer_we;

  assign timer_we = csr.csr_enable && (csr.csr_addr == `CLIC_CSR_TIMER);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      count_q <= '0;
    end else if (timer_we) begin
      count_q <= csr_wdata(csr.csr_op, count_q, csr.rs1_data, csr.rs1_zimm);
    end else if (count_q != '0) begin
      count_q <= count_q - word_t'(1);  // stops at zero
    end
  end

  // one pulse on the 1 -> 0 step, a write in that cycle cancels it
  assign pend_req_o = !timer_we && (count_q == word_t'(1));
  assign count_o    = count_q;

endmodule

// ==== rtl/clic_csr_bank.sv ====
// vector table and threshold registers
`timescale 1ns/1ps
`include "clic_cfg.svh"

module clic_csr_bank
  import clic_pkg::*;
(
  input  logic                            clk,
  input  logic                            reset_i,
  clic_csr_if.bank                        csr,
  clic_update_if.bank                     upd,
  input  word_t                           timer_data_i,
  input  logic                            timer_pend_i,
  input  depth_t                          depth_i,
  output entry_t    [`CLIC_VEC_SIZE-1:0]  entries_o,
  output vec_addr_t [`CLIC_VEC_SIZE-1:0]  vectors_o,
  output prio_t                           thresh_o,
  output word_t                           csr_data_o
);

  entry_t    [`CLIC_VEC_SIZE-1:0] entries_q;
  entry_t    [`CLIC_VEC_SIZE-1:0] entries_d;
  vec_addr_t [`CLIC_VEC_SIZE-1:0] vectors_q;
  prio_t                          thresh_q;
  logic      [`CLIC_VEC_SIZE-1:0] vec_sel;
  logic      [`CLIC_VEC_SIZE-1:0] entry_sel;
  logic                           thresh_sel;
  word_t                          wval;

  // address decode
  always_comb begin
    for (int k = 0; k < `CLIC_VEC_SIZE; k++) begin
      vec_sel[k]   = csr.csr_addr == `CLIC_CSR_VEC_BASE + csr_addr_t'(k);
      entry_sel[k] = csr.csr_addr == `CLIC_CSR_ENTRY_BASE + csr_addr_t'(k);
    end
  end

  assign thresh_sel = csr.csr_addr == `CLIC_CSR_THRESH;

  // old value is whatever the read mux shows for this address
  assign wval = csr_wdata(csr.csr_op, csr_data_o, csr.rs1_data, csr.rs1_zimm);

  // csr write first, then arbiter clear and timer set on top
  always_comb begin
    entries_d = entries_q;
    for (int k = 0; k < `CLIC_VEC_SIZE; k++) begin
      if (csr.csr_enable && entry_sel[k]) begin
        entries_d[k] = entry_t'(wval[$bits(entry_t)-1:0]);
      end
      if (upd.pend_clr[k]) begin
        entries_d[k].pended = 1'b0;
      end
    end
    if (timer_pend_i) begin
      entries_d[0].pended = 1'b1;  // timer owns vector 0
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      entries_q <= '0;
      vectors_q <= '0;
      thresh_q  <= '0;
    end else begin
      entries_q <= entries_d;
      for (int k = 0; k < `CLIC_VEC_SIZE; k++) begin
        if (csr.csr_enable && vec_sel[k]) begin
          vectors_q[k] <= wval[$bits(vec_addr_t)-1:0];
        end
      end
      if (upd.thresh_we) begin
        thresh_q <= upd.thresh_data;  // take or return beats the core
      end else if (csr.csr_enable && thresh_sel) begin
        thresh_q <= wval[$bits(prio_t)-1:0];
      end
    end
  end

  // read data, combinational from the address only
  always_comb begin
    csr_data_o = '0;
    if (csr.csr_addr == `CLIC_CSR_TIMER) begin
      csr_data_o = timer_data_i;
    end else if (thresh_sel) begin
      csr_data_o[$bits(prio_t)-1:0] = thresh_q;
    end else if (csr.csr_addr == `CLIC_CSR_DEPTH) begin
      csr_data_o[$bits(depth_t)-1:0] = depth_i;
    end else begin
      for (int k = 0; k < `CLIC_VEC_SIZE; k++) begin
        if (vec_sel[k]) begin
          csr_data_o[$bits(vec_addr_t)-1:0] = vectors_q[k];
        end
        if (entry_sel[k]) begin
          csr_data_o[$bits(entry_t)-1:0] = entries_q[k];
        end
      end
    end
  end

  assign entries_o = entries_q;
  assign vectors_o = vectors_q;
  assign thresh_o  = thresh_q;

endmodule

// ==== rtl/clic_update_if.sv ====
// arbiter state updates
`timescale 1ns/1ps
`include "clic_cfg.svh"

interface clic_update_if
  import clic_pkg::*;
();

  logic [`CLIC_VEC_SIZE-1:0] pend_clr;     // one hot
  logic                      thresh_we;
  prio_t                     thresh_data;
  logic                      push;
  logic                      pop;

  modport arbiter (
    output pend_clr, thresh_we, thresh_data, push, pop
  );

  modport bank (
    input pend_clr, thresh_we, thresh_data
  );

  modport stack (
    input push, pop
  );

endinterface

// ==== rtl/clic_csr_if.sv ====
// core csr access bundle
`timescale 1ns/1ps
`include "clic_cfg.svh"

interface clic_csr_if
  import clic_pkg::*;
();

  logic                        csr_enable;  // single cycle strobe
  csr_addr_t                   csr_addr;
  csr_op_e                     csr_op;
  logic [`CLIC_ZIMM_WIDTH-1:0] rs1_zimm;
  word_t                       rs1_data;

  // register bank view
  modport bank (
    input csr_enable, csr_addr, csr_op, rs1_zimm, rs1_data
  );

  // timer only needs its own address, same signals
  modport timer (
    input csr_enable, csr_addr, csr_op, rs1_zimm, rs1_data
  );

endinterface

// ==== rtl/clic_pkg.sv ====
// clic shared types
`include "clic_cfg.svh"

package clic_pkg;

  typedef logic [`CLIC_XLEN-1:0]         word_t;
  typedef logic [`CLIC_CSR_AW-1:0]       csr_addr_t;
  typedef logic [`CLIC_PRIO_WIDTH-1:0]   prio_t;
  typedef logic [`CLIC_PRIO_WIDTH:0]     depth_t;     // 0 up to full stack
  typedef logic [`CLIC_PC_WIDTH-1:0]     pc_t;
  typedef logic [`CLIC_PC_WIDTH-3:0]     vec_addr_t;  // word address

  // funct3 encoding of the zicsr instructions
  typedef enum logic [2:0] {
    CSR_RW  = 3'b001,
    CSR_RS  = 3'b010,
    CSR_RC  = 3'b011,
    CSR_RWI = 3'b101,
    CSR_RSI = 3'b110,
    CSR_RCI = 3'b111
  } csr_op_e;

  typedef enum logic {
    PC_NORMAL    = 1'b0,
    PC_INTERRUPT = 1'b1
  } pc_sel_e;

  typedef struct packed {
    prio_t prio;
    logic  enabled;
    logic  pended;   // lsb, reachable by a 5 bit immediate
  } entry_t;

  typedef struct packed {
    pc_t   pc;
    prio_t thresh;
  } stack_entry_t;

  // new csr value for write, set and clear ops
  function automatic word_t csr_wdata(csr_op_e op, word_t old, word_t rs1,
                                      logic [`CLIC_ZIMM_WIDTH-1:0] zimm);
    word_t src;
    src = (op inside {CSR_RWI, CSR_RSI, CSR_RCI}) ? word_t'(zimm) : rs1;
    case (op)
      CSR_RW, CSR_RWI: return src;
      CSR_RS, CSR_RSI: return old | src;
      CSR_RC, CSR_RCI: return old & ~src;
      default:         return old;  // reserved codes leave the register alone
    endcase
  endfunction

endpackage

// ==== rtl/clic_cfg.svh ====
// clic configuration constants
`ifndef CLIC_CFG_SVH
`define CLIC_CFG_SVH

// vector table size and field widths
`define CLIC_VEC_SIZE    8
`define CLIC_PRIO_WIDTH  3
`define CLIC_PC_WIDTH    16   // byte address of instruction memory
`define CLIC_XLEN        32
`define CLIC_CSR_AW      12
`define CLIC_ZIMM_WIDTH  5

// one return slot per priority level
`define CLIC_STACK_DEPTH (1 << `CLIC_PRIO_WIDTH)

// csr map
`define CLIC_CSR_TIMER      12'h400
`define CLIC_CSR_THRESH     12'h347
`define CLIC_CSR_DEPTH      12'h350  // read only
`define CLIC_CSR_VEC_BASE   12'hB00
`define CLIC_CSR_ENTRY_BASE 12'hB20

// pc of all ones marks a return from interrupt
`define CLIC_RET_MARKER {`CLIC_PC_WIDTH{1'b1}}

`endif
